// ==== include/issue_defines.svh ====
/* issue stage widths and counts */

`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// scalar register file
`define NUM_REGS 32
`define REG_W    5
`define DATA_W   32

// one status row per functional unit
`define NUM_FU   5

// matrix register id, carried as a number only
`define MREG_W   4

// age counter, saturates at all ones (7)
`define AGE_W    3

`endif

// ==== src/issue_pkg.sv ====
/* issue stage types */

`include "issue_defines.svh"

package issue_pkg;

    // row index and functional unit id are the same number
    typedef enum logic [2:0] {
        ALU    = 3'd0,
        LDST   = 3'd1,
        BRANCH = 3'd2,
        MLDST  = 3'd3,
        GEMM   = 3'd4
    } fu_e;

    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        WAIT  = 2'd1,
        RDY   = 2'd2,
        EX    = 2'd3
    } row_state_e;

    // 0 = operand available, k+1 = waiting on unit k
    typedef logic [2:0] tag_t;

    typedef struct packed {
        logic [`REG_W-1:0] rs1;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rd;
        tag_t              t1;
        tag_t              t2;
    } scalar_row_t;

    typedef struct packed {
        logic [`REG_W-1:0]  rs1;
        logic [`REG_W-1:0]  rs2;
        logic [`MREG_W-1:0] ms1;
        logic [`MREG_W-1:0] ms2;
        logic [`MREG_W-1:0] ms3;
        tag_t               t1;
        tag_t               t2;
        tag_t               t3;
    } matrix_row_t;

    typedef struct packed {
        logic        en;
        fu_e         fu;
        scalar_row_t s_row;
        matrix_row_t m_row;
    } dispatch_t;

    typedef struct packed {
        logic [`NUM_FU-1:0] done;
        logic               s_rw_en;
        logic [`REG_W-1:0]  s_rw;
        logic [`DATA_W-1:0] s_wdata;
    } wb_t;

    typedef struct packed {
        logic               valid;
        fu_e                fu;
        logic [`DATA_W-1:0] rdat1;
        logic [`DATA_W-1:0] rdat2;
        logic [`MREG_W-1:0] ms1;
        logic [`MREG_W-1:0] ms2;
        logic [`MREG_W-1:0] ms3;
    } issue_t;

    // wakeup: a tag naming a completing unit becomes available
    function automatic tag_t clear_tag(tag_t tag, logic [`NUM_FU-1:0] done);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `NUM_FU; k++) begin
            if (done[k] && (tag == tag_t'(k + 1))) begin
                hit = 1'b1;
            end
        end
        return hit ? tag_t'(0) : tag;
    endfunction

endpackage

// ==== src/regfile.sv ====
/* scalar register file */

`timescale 1ns/100ps
`include "issue_defines.svh"

module regfile (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               wen,
    input  logic [`REG_W-1:0]  wsel,
    input  logic [`DATA_W-1:0] wdata,
    input  logic [`REG_W-1:0]  rsel1,
    input  logic [`REG_W-1:0]  rsel2,
    output logic [`DATA_W-1:0] rdat1,
    output logic [`DATA_W-1:0] rdat2
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    // x0 is hardwired, same-cycle write is forwarded
    always_comb begin
        if (rsel1 == '0) begin
            rdat1 = '0;
        end else if (wen && (wsel == rsel1)) begin
            rdat1 = wdata;
        end else begin
            rdat1 = regs[rsel1];
        end

        if (rsel2 == '0) begin
            rdat2 = '0;
        end else if (wen && (wsel == rsel2)) begin
            rdat2 = wdata;
        end else begin
            rdat2 = regs[rsel2];
        end
    end

endmodule

// ==== src/fust_scalar.sv ====
/* scalar status rows */

`timescale 1ns/100ps
`include "issue_defines.svh"

module fust_scalar (
    input  logic                       CLK,
    input  logic                       nRST,
    input  issue_pkg::dispatch_t       dispatch,
    input  logic [`NUM_FU-1:0]         done,
    output issue_pkg::scalar_row_t [2:0] rows
);

    import issue_pkg::*;

    scalar_row_t [2:0] n_rows;

    // tags that match a finishing unit are cleared before storing
    function automatic scalar_row_t wake_row(scalar_row_t row, logic [`NUM_FU-1:0] dn);
        scalar_row_t r;
        r    = row;
        r.t1 = clear_tag(row.t1, dn);
        r.t2 = clear_tag(row.t2, dn);
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (dispatch.en && (dispatch.fu == fu_e'(i))) begin
                // new payload, already woken by this cycle's done
                n_rows[i] = wake_row(dispatch.s_row, done);
            end else begin
                n_rows[i] = wake_row(rows[i], done);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            rows <= n_rows;
        end
    end

endmodule

// ==== src/fust_matrix.sv ====
/* matrix status rows */

`timescale 1ns/100ps
`include "issue_defines.svh"

module fust_matrix (
    input  logic                   CLK,
    input  logic                   nRST,
    input  issue_pkg::dispatch_t   dispatch,
    input  logic [`NUM_FU-1:0]     done,
    output issue_pkg::matrix_row_t mldst_row,
    output issue_pkg::matrix_row_t gemm_row
);

    import issue_pkg::*;

    matrix_row_t n_mldst_row;
    matrix_row_t n_gemm_row;

    // either load a dispatched payload or keep the row, then wake its tags
    function automatic matrix_row_t next_row(matrix_row_t cur, logic hit,
                                             matrix_row_t din, logic [`NUM_FU-1:0] dn);
        matrix_row_t r;
        r    = hit ? din : cur;
        r.t1 = clear_tag(r.t1, dn);
        r.t2 = clear_tag(r.t2, dn);
        r.t3 = clear_tag(r.t3, dn);
        return r;
    endfunction

    always_comb begin
        n_mldst_row = next_row(mldst_row, dispatch.en && (dispatch.fu == MLDST),
                               dispatch.m_row, done);
        n_gemm_row  = next_row(gemm_row, dispatch.en && (dispatch.fu == GEMM),
                               dispatch.m_row, done);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mldst_row <= '0;
            gemm_row  <= '0;
        end else begin
            mldst_row <= n_mldst_row;
            gemm_row  <= n_gemm_row;
        end
    end

endmodule

// ==== src/issue_scheduler.sv ====
/* issue scheduler */

`timescale 1ns/100ps
`include "issue_defines.svh"

module issue_scheduler (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         dispatch_en,
    input  issue_pkg::fu_e               dispatch_fu,
    input  logic [`NUM_FU-1:0]           done,
    input  logic                         freeze,
    input  issue_pkg::scalar_row_t [2:0] scalar_rows,
    input  issue_pkg::matrix_row_t       mldst_row,
    input  issue_pkg::matrix_row_t       gemm_row,
    input  logic [`DATA_W-1:0]           rdat1,
    input  logic [`DATA_W-1:0]           rdat2,
    output logic [`REG_W-1:0]            rsel1,
    output logic [`REG_W-1:0]            rsel2,
    output logic [`NUM_FU-1:0]           busy,
    output issue_pkg::issue_t            issue_out
);

    import issue_pkg::*;

    row_state_e [`NUM_FU-1:0]            state;
    row_state_e [`NUM_FU-1:0]            n_state;
    logic [`NUM_FU-1:0][`AGE_W-1:0]      age;
    logic [`NUM_FU-1:0][`AGE_W-1:0]      n_age;
    logic [`NUM_FU-1:0]                  disp_hit;
    logic [`NUM_FU-1:0]                  tags_clear;
    logic [`NUM_FU-1:0]                  rdy;
    logic [`NUM_FU-1:0]                  sel;
    logic                                found;
    logic [`AGE_W-1:0]                   best_age;
    fu_e                                 sel_idx;
    issue_t                              n_issue;

    // stored tags only, a done this cycle shows up next cycle
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            tags_clear[i] = (scalar_rows[i].t1 == '0) && (scalar_rows[i].t2 == '0);
        end
        tags_clear[MLDST] = (mldst_row.t1 == '0) && (mldst_row.t2 == '0);
        tags_clear[GEMM]  = (gemm_row.t1 == '0) && (gemm_row.t2 == '0) &&
                            (gemm_row.t3 == '0);

        for (int i = 0; i < `NUM_FU; i++) begin
            disp_hit[i] = dispatch_en && (dispatch_fu == fu_e'(i));
            rdy[i]      = ((state[i] == WAIT) || (state[i] == RDY)) && tags_clear[i];
            busy[i]     = (state[i] != EMPTY);
        end
    end

    // oldest ready row wins, strict compare keeps ties on the lower index
    always_comb begin
        found    = 1'b0;
        best_age = '0;
        sel_idx  = ALU;
        sel      = '0;
        if (!freeze) begin
            for (int i = 0; i < `NUM_FU; i++) begin
                if (rdy[i] && (!found || (age[i] > best_age))) begin
                    found    = 1'b1;
                    best_age = age[i];
                    sel_idx  = fu_e'(i);
                end
            end
        end
        if (found) begin
            sel[sel_idx] = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_FU; i++) begin
            n_state[i] = state[i];
            case (state[i])
                EMPTY: begin
                    if (disp_hit[i]) begin
                        n_state[i] = WAIT;
                    end
                end
                WAIT: begin
                    if (sel[i]) begin
                        n_state[i] = EX;
                    end else if (rdy[i]) begin
                        n_state[i] = RDY;
                    end
                end
                RDY: begin
                    if (sel[i]) begin
                        n_state[i] = EX;
                    end
                end
                EX: begin
                    // a dispatch may reuse the row in its own done cycle
                    if (done[i]) begin
                        n_state[i] = disp_hit[i] ? WAIT : EMPTY;
                    end
                end
                default: n_state[i] = EMPTY;
            endcase

            n_age[i] = age[i];
            if (disp_hit[i]) begin
                n_age[i] = '0;
            end else if ((state[i] == WAIT) || (state[i] == RDY)) begin
                if (age[i] != '1) begin
                    n_age[i] = age[i] + 1'b1;
                end
            end
        end
    end

    // register read ports follow the picked row
    always_comb begin
        rsel1 = '0;
        rsel2 = '0;
        if (found) begin
            case (sel_idx)
                ALU, LDST, BRANCH: begin
                    rsel1 = scalar_rows[sel_idx[1:0]].rs1;
                    rsel2 = scalar_rows[sel_idx[1:0]].rs2;
                end
                MLDST: begin
                    rsel1 = mldst_row.rs1;
                    rsel2 = mldst_row.rs2;
                end
                default: begin
                    rsel1 = '0;
                    rsel2 = '0;
                end
            endcase
        end
    end

    always_comb begin
        n_issue = issue_out;
        if (!freeze) begin
            n_issue = '0;
            if (found) begin
                n_issue.valid = 1'b1;
                n_issue.fu    = sel_idx;
                if (sel_idx == GEMM) begin
                    // matrix ids only, no scalar operands
                    n_issue.ms1 = gemm_row.ms1;
                    n_issue.ms2 = gemm_row.ms2;
                    n_issue.ms3 = gemm_row.ms3;
                end else begin
                    n_issue.rdat1 = rdat1;
                    n_issue.rdat2 = rdat2;
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `NUM_FU; i++) begin
                state[i] <= EMPTY;
            end
            age       <= '0;
            issue_out <= '0;
        end else begin
            state     <= n_state;
            age       <= n_age;
            issue_out <= n_issue;
        end
    end

endmodule

// ==== src/issue.sv ====
/* issue stage top */

`timescale 1ns/100ps
`include "issue_defines.svh"

module issue (
    input  logic                          CLK,
    input  logic                          nRST,
    input  issue_pkg::dispatch_t          dispatch,
    input  issue_pkg::wb_t                wb,
    input  logic                          freeze,
    output issue_pkg::issue_t             issue_out,
    output logic [`NUM_FU-1:0]            busy,
    output issue_pkg::scalar_row_t [2:0]  scalar_rows,
    output issue_pkg::matrix_row_t [1:0]  matrix_rows
);

    logic [`REG_W-1:0]  rsel1;
    logic [`REG_W-1:0]  rsel2;
    logic [`DATA_W-1:0] rdat1;
    logic [`DATA_W-1:0] rdat2;

    regfile u_regfile (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb.s_rw_en),
        .wsel  (wb.s_rw),
        .wdata (wb.s_wdata),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    fust_scalar u_fust_scalar (
        .CLK      (CLK),
        .nRST     (nRST),
        .dispatch (dispatch),
        .done     (wb.done),
        .rows     (scalar_rows)
    );

    // matrix_rows[0] is the load/store row, [1] the GEMM row
    fust_matrix u_fust_matrix (
        .CLK       (CLK),
        .nRST      (nRST),
        .dispatch  (dispatch),
        .done      (wb.done),
        .mldst_row (matrix_rows[0]),
        .gemm_row  (matrix_rows[1])
    );

    issue_scheduler u_scheduler (
        .CLK         (CLK),
        .nRST        (nRST),
        .dispatch_en (dispatch.en),
        .dispatch_fu (dispatch.fu),
        .done        (wb.done),
        .freeze      (freeze),
        .scalar_rows (scalar_rows),
        .mldst_row   (matrix_rows[0]),
        .gemm_row    (matrix_rows[1]),
        .rdat1       (rdat1),
        .rdat2       (rdat2),
        .rsel1       (rsel1),
        .rsel2       (rsel2),
        .busy        (busy),
        .issue_out   (issue_out)
    );

endmodule

// ==== verif/issue_tb.sv ====
/* issue stage testbench */

`timescale 1ns/100ps
`include "issue_defines.svh"

module issue_tb;

    import issue_pkg::*;

    logic                   CLK;
    logic                   nRST;
    dispatch_t              dispatch;
    wb_t                    wb;
    logic                   freeze;
    issue_t                 issue_out;
    logic [`NUM_FU-1:0]     busy;
    scalar_row_t [2:0]      scalar_rows;
    matrix_row_t [1:0]      matrix_rows;

    // shadow model, always one edge ahead of the DUT outputs
    logic [`DATA_W-1:0]     shadow_rf [`NUM_REGS];
    row_state_e             m_state [`NUM_FU];
    logic [`AGE_W-1:0]      m_age [`NUM_FU];
    logic [`REG_W-1:0]      m_rs1 [`NUM_FU];
    logic [`REG_W-1:0]      m_rs2 [`NUM_FU];
    logic [`REG_W-1:0]      m_rd [`NUM_FU];
    logic [`MREG_W-1:0]     m_ms1 [`NUM_FU];
    logic [`MREG_W-1:0]     m_ms2 [`NUM_FU];
    logic [`MREG_W-1:0]     m_ms3 [`NUM_FU];
    tag_t                   m_tag [`NUM_FU][3];
    issue_t                 expected;
    logic [`NUM_FU-1:0]     exp_busy;
    logic [31:0]            seed;
    string                  test_name;

    issue uut (
        .CLK         (CLK),
        .nRST        (nRST),
        .dispatch    (dispatch),
        .wb          (wb),
        .freeze      (freeze),
        .issue_out   (issue_out),
        .busy        (busy),
        .scalar_rows (scalar_rows),
        .matrix_rows (matrix_rows)
    );

    always #50 CLK = ~CLK;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [`DATA_W-1:0] exp, logic [`DATA_W-1:0] act);
        assert (exp === act) else
            report_failure($sformatf("MISMATCH %s %s expected %h actual %h",
                                     test_name, what, exp, act));
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond === 1'b1) else
            report_failure($sformatf("%s: %s", test_name, what));
    endtask

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic int rnd(int n);
        return int'((lcg() >> 16) % n);
    endfunction

    function automatic tag_t wake(tag_t t, logic [`NUM_FU-1:0] dn);
        if ((t != 0) && (t <= `NUM_FU) && dn[t - 1]) begin
            return tag_t'(0);
        end
        return t;
    endfunction

    // only the GEMM row waits on its third tag
    function automatic logic row_ready(int i);
        return ((m_state[i] == WAIT) || (m_state[i] == RDY)) &&
               (m_tag[i][0] == 0) && (m_tag[i][1] == 0) &&
               ((i != GEMM) || (m_tag[i][2] == 0));
    endfunction

    // oldest ready row, lower index on a tie
    function automatic int pick_row(logic frz);
        int best;
        best = -1;
        if (!frz) begin
            for (int i = 0; i < `NUM_FU; i++) begin
                if (row_ready(i) && ((best < 0) || (m_age[i] > m_age[best]))) begin
                    best = i;
                end
            end
        end
        return best;
    endfunction

    function automatic logic [`DATA_W-1:0] read_reg(logic [`REG_W-1:0] r, wb_t w);
        if (r == 0) begin
            return '0;
        end
        if (w.s_rw_en && (w.s_rw == r)) begin
            return w.s_wdata;
        end
        return shadow_rf[r];
    endfunction

    // expected issue bundle after the coming edge
    function automatic issue_t ref_issue(wb_t w, logic frz);
        issue_t e;
        int     s;
        if (frz) begin
            return expected;
        end
        e = '0;
        s = pick_row(frz);
        if (s >= 0) begin
            e.valid = 1'b1;
            e.fu    = fu_e'(s);
            if (s == GEMM) begin
                e.ms1 = m_ms1[s];
                e.ms2 = m_ms2[s];
                e.ms3 = m_ms3[s];
            end else begin
                e.rdat1 = read_reg(m_rs1[s], w);
                e.rdat2 = read_reg(m_rs2[s], w);
            end
        end
        return e;
    endfunction

    function automatic scalar_row_t model_scalar_row(int i);
        scalar_row_t r;
        r.rs1 = m_rs1[i];
        r.rs2 = m_rs2[i];
        r.rd  = m_rd[i];
        r.t1  = m_tag[i][0];
        r.t2  = m_tag[i][1];
        return r;
    endfunction

    function automatic matrix_row_t model_matrix_row(int i);
        matrix_row_t r;
        r.rs1 = m_rs1[i];
        r.rs2 = m_rs2[i];
        r.ms1 = m_ms1[i];
        r.ms2 = m_ms2[i];
        r.ms3 = m_ms3[i];
        r.t1  = m_tag[i][0];
        r.t2  = m_tag[i][1];
        r.t3  = m_tag[i][2];
        return r;
    endfunction

    // loopback rows against the shadow rows
    task automatic check_rows();
        scalar_row_t s_exp;
        matrix_row_t m_exp;
        for (int i = 0; i < 3; i++) begin
            s_exp = model_scalar_row(i);
            assert (scalar_rows[i] === s_exp) else
                report_failure($sformatf("MISMATCH %s scalar row %0d expected %h actual %h",
                                         test_name, i, s_exp, scalar_rows[i]));
        end
        for (int i = 0; i < 2; i++) begin
            m_exp = model_matrix_row(MLDST + i);
            assert (matrix_rows[i] === m_exp) else
                report_failure($sformatf("MISMATCH %s matrix row %0d expected %h actual %h",
                                         test_name, i, m_exp, matrix_rows[i]));
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow_rf[i] = '0;
        end
        for (int i = 0; i < `NUM_FU; i++) begin
            m_state[i] = EMPTY;
            m_age[i]   = '0;
            m_rs1[i]   = '0;
            m_rs2[i]   = '0;
            m_rd[i]    = '0;
            m_ms1[i]   = '0;
            m_ms2[i]   = '0;
            m_ms3[i]   = '0;
            for (int j = 0; j < 3; j++) begin
                m_tag[i][j] = '0;
            end
        end
    endtask

    task automatic model_step(dispatch_t d, wb_t w, logic frz);
        int   s;
        logic hit;
        logic rdy [`NUM_FU];
        s = pick_row(frz);
        for (int i = 0; i < `NUM_FU; i++) begin
            rdy[i] = row_ready(i);
        end
        for (int i = 0; i < `NUM_FU; i++) begin
            hit = d.en && (int'(d.fu) == i);
            case (m_state[i])
                EMPTY: if (hit) m_state[i] = WAIT;
                WAIT: begin
                    if (s == i) begin
                        m_state[i] = EX;
                    end else if (rdy[i]) begin
                        m_state[i] = RDY;
                    end
                end
                RDY: if (s == i) m_state[i] = EX;
                default: begin
                    if (w.done[i]) begin
                        m_state[i] = hit ? WAIT : EMPTY;
                    end
                end
            endcase
            if (hit) begin
                m_age[i] = '0;
            end else if (((m_state[i] == WAIT) || (m_state[i] == RDY) || (s == i)) &&
                         (m_age[i] != 3'd7)) begin
                m_age[i] = m_age[i] + 3'd1;
            end
            if (hit && (i < 3)) begin
                m_rs1[i]    = d.s_row.rs1;
                m_rs2[i]    = d.s_row.rs2;
                m_rd[i]     = d.s_row.rd;
                m_tag[i][0] = d.s_row.t1;
                m_tag[i][1] = d.s_row.t2;
                m_tag[i][2] = '0;
            end else if (hit) begin
                m_rs1[i]    = d.m_row.rs1;
                m_rs2[i]    = d.m_row.rs2;
                m_ms1[i]    = d.m_row.ms1;
                m_ms2[i]    = d.m_row.ms2;
                m_ms3[i]    = d.m_row.ms3;
                m_tag[i][0] = d.m_row.t1;
                m_tag[i][1] = d.m_row.t2;
                m_tag[i][2] = d.m_row.t3;
            end
            for (int j = 0; j < 3; j++) begin
                m_tag[i][j] = wake(m_tag[i][j], w.done);
            end
        end
        if (w.s_rw_en && (w.s_rw != 0)) begin
            shadow_rf[w.s_rw] = w.s_wdata;
        end
    endtask

    // inputs are steady at the falling edge, outputs too
    always @(negedge CLK) begin
        if (!nRST) begin
            model_reset();
            expected = '0;
            exp_busy = '0;
        end else begin
            assert (issue_out === expected) else
                report_failure($sformatf("MISMATCH %s issue_out expected %h actual %h",
                                         test_name, expected, issue_out));
            assert (busy === exp_busy) else
                report_failure($sformatf("MISMATCH %s busy expected %b actual %b",
                                         test_name, exp_busy, busy));
            check_rows();
            expected = ref_issue(wb, freeze);
            model_step(dispatch, wb, freeze);
            for (int i = 0; i < `NUM_FU; i++) begin
                exp_busy[i] = (m_state[i] != EMPTY);
            end
        end
    end

    task automatic drive(dispatch_t d, wb_t w, logic f);
        @(posedge CLK);
        dispatch <= d;
        wb       <= w;
        freeze   <= f;
    endtask

    task automatic idle();
        drive('0, '0, 1'b0);
    endtask

    function automatic dispatch_t mk_scalar(fu_e fu, int rs1, int rs2, int t1, int t2);
        dispatch_t d;
        d           = '0;
        d.en        = 1'b1;
        d.fu        = fu;
        d.s_row.rs1 = `REG_W'(rs1);
        d.s_row.rs2 = `REG_W'(rs2);
        d.s_row.t1  = tag_t'(t1);
        d.s_row.t2  = tag_t'(t2);
        return d;
    endfunction

    function automatic dispatch_t mk_matrix(fu_e fu, int rs1, int rs2, int ms1, int ms2,
                                            int ms3, int t1, int t2, int t3);
        dispatch_t d;
        d           = '0;
        d.en        = 1'b1;
        d.fu        = fu;
        d.m_row.rs1 = `REG_W'(rs1);
        d.m_row.rs2 = `REG_W'(rs2);
        d.m_row.ms1 = `MREG_W'(ms1);
        d.m_row.ms2 = `MREG_W'(ms2);
        d.m_row.ms3 = `MREG_W'(ms3);
        d.m_row.t1  = tag_t'(t1);
        d.m_row.t2  = tag_t'(t2);
        d.m_row.t3  = tag_t'(t3);
        return d;
    endfunction

    function automatic wb_t wb_done(logic [`NUM_FU-1:0] mask);
        wb_t w;
        w      = '0;
        w.done = mask;
        return w;
    endfunction

    task automatic finish_rows(logic [`NUM_FU-1:0] mask);
        drive('0, wb_done(mask), 1'b0);
    endtask

    task automatic wait_issue(fu_e fu, int limit);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            idle();
            #1;
            if (issue_out.valid && (issue_out.fu == fu)) begin
                seen = 1'b1;
            end else begin
                n++;
                if (n >= limit) begin
                    report_failure($sformatf("%s: timed out waiting for %s to issue",
                                             test_name, fu.name()));
                end
            end
        end
    endtask

    // complete everything until all rows are empty
    task automatic drain();
        int n;
        n = 0;
        #1;
        while (busy != '0) begin
            drive('0, wb_done('1), 1'b0);
            #1;
            n++;
            if (n > 20) begin
                report_failure($sformatf("%s: rows still busy after draining", test_name));
            end
        end
    endtask

    task automatic random_mix(int cycles);
        dispatch_t d;
        wb_t       w;
        logic      f;
        int        u;
        for (int c = 0; c < cycles; c++) begin
            // past the falling edge the model holds the state these inputs will meet
            @(negedge CLK);
            #1;
            w = '0;
            for (int k = 0; k < `NUM_FU; k++) begin
                if ((m_state[k] == EX) && (rnd(4) == 0)) begin
                    w.done[k] = 1'b1;
                end
            end
            if (rnd(2) == 0) begin
                w.s_rw_en = 1'b1;
                w.s_rw    = `REG_W'(rnd(`NUM_REGS));
                w.s_wdata = lcg();
            end
            f = (rnd(8) == 0);
            d = '0;
            u = rnd(`NUM_FU);
            if (((m_state[u] == EMPTY) || ((m_state[u] == EX) && w.done[u])) &&
                (rnd(3) != 0)) begin
                // a tag only names a unit that is executing, so it clears eventually
                if (u < 3) begin
                    d = mk_scalar(fu_e'(u), rnd(32), rnd(32), rand_tag(), rand_tag());
                    d.s_row.rd = `REG_W'(rnd(32));
                end else begin
                    d = mk_matrix(fu_e'(u), rnd(32), rnd(32), rnd(16), rnd(16), rnd(16),
                                  rand_tag(), rand_tag(), rand_tag());
                end
            end
            drive(d, w, f);
        end
    endtask

    function automatic int rand_tag();
        int u;
        u = rnd(`NUM_FU);
        if ((m_state[u] == EX) && (rnd(2) == 0)) begin
            return u + 1;
        end
        return 0;
    endfunction

    initial begin
        issue_t held;
        logic [`DATA_W-1:0] val;
        CLK       = 1'b0;
        nRST      = 1'b0;
        dispatch  = '0;
        wb        = '0;
        freeze    = 1'b0;
        seed      = 32'd67788;
        test_name = "reset";
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        #1;
        check_true(!issue_out.valid && (busy == '0), "outputs not clear after reset");

        test_name = "register read";
        for (int i = 0; i < 8; i++) begin
            drive('0, '{done: '0, s_rw_en: 1'b1, s_rw: `REG_W'(rnd(32)), s_wdata: lcg()},
                  1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            drive(mk_scalar(ALU, rnd(32), (i == 0) ? 0 : rnd(32), 0, 0), '0, 1'b0);
            idle();
            #1;
            check_true(!issue_out.valid, "issued one edge early");
            idle();
            #1;
            check_true(issue_out.valid && (issue_out.fu == ALU), "not issued after two edges");
            if (i == 0) begin
                check_value("x0 read", '0, issue_out.rdat2);
            end
            finish_rows(5'b00001);
        end

        test_name = "tag wakeup";
        drive(mk_scalar(ALU, 1, 2, 0, 0), '0, 1'b0);
        wait_issue(ALU, 4);
        drive(mk_scalar(LDST, 3, 4, ALU + 1, 0), '0, 1'b0);
        repeat (4) begin
            idle();
            #1;
            check_true(!(issue_out.valid && (issue_out.fu == LDST)), "issued with a pending tag");
        end
        finish_rows(5'b00001);
        idle();
        #1;
        check_true(!busy[ALU], "ALU row not freed by done");
        wait_issue(LDST, 4);
        drain();

        test_name = "oldest first";
        drive(mk_scalar(BRANCH, 1, 1, 0, 0), '0, 1'b0);
        wait_issue(BRANCH, 4);
        drive(mk_scalar(ALU, 5, 6, BRANCH + 1, 0), '0, 1'b0);
        drive(mk_matrix(GEMM, 0, 0, 1, 2, 3, BRANCH + 1, 0, 0), '0, 1'b0);
        repeat (8) idle();
        drive(mk_scalar(LDST, 7, 8, 0, BRANCH + 1), '0, 1'b0);
        drive(mk_matrix(MLDST, 9, 10, 0, 0, 0, BRANCH + 1, 0, 0), '0, 1'b0);
        finish_rows(5'b00100);
        wait_issue(ALU, 4);
        wait_issue(GEMM, 1);
        wait_issue(LDST, 1);
        wait_issue(MLDST, 1);
        drain();

        test_name = "gemm";
        drive(mk_matrix(GEMM, 0, 0, 11, 12, 13, ALU + 1, LDST + 1, MLDST + 1), '0, 1'b0);
        repeat (3) idle();
        finish_rows(5'b00001);
        finish_rows(5'b00010);
        repeat (2) idle();
        #1;
        check_true(busy[GEMM] && !(issue_out.valid && (issue_out.fu == GEMM)),
                   "GEMM issued before all tags cleared");
        finish_rows(5'b01000);
        wait_issue(GEMM, 4);
        check_value("ms1", 32'd11, 32'(issue_out.ms1));
        check_value("ms3", 32'd13, 32'(issue_out.ms3));
        check_value("gemm rdat1", '0, issue_out.rdat1);
        check_value("gemm rdat2", '0, issue_out.rdat2);
        drain();
        test_name = "bypass";
        val = lcg();
        drive(mk_scalar(ALU, 9, 9, 0, 0), '0, 1'b0);
        drive('0, '{done: '0, s_rw_en: 1'b1, s_rw: 5'd9, s_wdata: val}, 1'b0);
        idle();
        #1;
        check_value("bypassed rdat1", val, issue_out.rdat1);
        drain();

        test_name = "freeze";
        drive(mk_scalar(ALU, 2, 3, 0, 0), '0, 1'b0);
        idle();
        drive('0, '0, 1'b1);
        #1;
        check_true(issue_out.valid && (issue_out.fu == ALU), "ALU not issued before freeze");
        held = issue_out;
        drive(mk_scalar(LDST, 4, 5, 0, 0), '0, 1'b1);
        drive(mk_scalar(BRANCH, 6, 7, ALU + 1, 0), '0, 1'b1);
        drive('0, wb_done(5'b00001), 1'b1);
        drive('0, '0, 1'b1);
        #1;
        check_true(!busy[ALU], "completion did not free the row under freeze");
        repeat (2) begin
            drive('0, '0, 1'b1);
            #1;
            check_true(issue_out === held, "issue register changed under freeze");
        end
        check_true(scalar_rows[BRANCH].t1 == '0, "tag not cleared under freeze");
        wait_issue(LDST, 4);
        wait_issue(BRANCH, 2);
        drain();

        test_name = "random mix";
        random_mix(400);
        drain();

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== issue.f ====
+incdir+include
src/issue_pkg.sv
src/regfile.sv
src/fust_scalar.sv
src/fust_matrix.sv
src/issue_scheduler.sv
src/issue.sv
verif/issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= issue_tb
FILELIST  ?= issue.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
